// ==== source/chroni_pkg.sv ====
`default_nettype none

package chroni_pkg;

   typedef logic [16:0] vram_addr_t;   // 128 KiB of video memory
   typedef logic [7:0]  byte_t;
   typedef logic [15:0] color_t;       // rgb565
   typedef logic [6:0]  col_idx_t;
   typedef logic [7:0]  pal_idx_t;
   typedef logic [2:0]  font_scan_t;

   // cpu_addr[15:7] of the register window
   localparam logic [8:0] REG_BASE = 9'h120;

   localparam logic [6:0] REG_DL_LO     = 7'h00;
   localparam logic [6:0] REG_DL_HI     = 7'h01;
   localparam logic [6:0] REG_CHARSET   = 7'h02;
   localparam logic [6:0] REG_PAL_INDEX = 7'h04;
   localparam logic [6:0] REG_PAL_DATA  = 7'h05;   // low byte, then high byte
   localparam logic [6:0] REG_VADDR_LO  = 7'h06;
   localparam logic [6:0] REG_VADDR_HI  = 7'h07;
   localparam logic [6:0] REG_VADDR_TOP = 7'h08;   // bit 0 is address bit 16
   localparam logic [6:0] REG_VDATA     = 7'h09;

   // display list opcodes, low nibble of the instruction byte
   localparam logic [3:0] DL_BLANK = 4'd0;   // bits 6:4 hold the line count minus one
   localparam logic [3:0] DL_END   = 4'd1;
   localparam logic [3:0] DL_TEXT  = 4'd2;
   localparam int DL_LMS_BIT = 6;

   localparam int TEXT_COLS    = 16;
   localparam int CELL_LINES   = 8;
   localparam int VRAM_LATENCY = 1;

   typedef enum logic [2:0] {
      DLS_IDLE,
      DLS_READ,
      DLS_READ_WAIT,
      DLS_LMS,
      DLS_LMS_READ,
      DLS_EXEC,
      DLS_WAIT_LINE
   } dl_state_t;

   typedef enum logic [2:0] {
      FS_IDLE,
      FS_TEXT_READ,
      FS_ATTR_READ,
      FS_FONT_ADDR,
      FS_FONT_WAIT,
      FS_GLYPH_SEND
   } fetch_state_t;

endpackage

`default_nettype wire

// ==== source/reg_decode.sv ====
`default_nettype none

module reg_decode (
   input  wire                         sys_clk,
   input  wire                         rst_n,
   input  wire [15:0]                  cpu_addr,
   input  wire chroni_pkg::byte_t      cpu_wr_data,
   input  wire                         cpu_wr_en,
   output chroni_pkg::vram_addr_t      dl_base,
   output chroni_pkg::byte_t           charset_base,
   output logic                        vram_wr_en,
   output chroni_pkg::vram_addr_t      vram_wr_addr,
   output chroni_pkg::byte_t           vram_wr_data,
   output logic                        pal_wr_en,
   output chroni_pkg::pal_idx_t        pal_wr_addr,
   output chroni_pkg::color_t          pal_wr_data
);
   import chroni_pkg::*;

   logic [15:0] dl_reg;   // list start, lower 64 KiB only
   vram_addr_t  vaddr;
   pal_idx_t    pal_idx;
   byte_t       pal_lo;
   logic        pal_hi;   // next data write is the high byte
   logic        reg_wr;

   assign reg_wr  = cpu_wr_en && (cpu_addr[15:7] == REG_BASE);
   assign dl_base = {1'b0, dl_reg};

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         dl_reg       <= '0;
         charset_base <= '0;
         vaddr        <= '0;
         pal_idx      <= '0;
         pal_hi       <= 1'b0;
         vram_wr_en   <= 1'b0;
         pal_wr_en    <= 1'b0;
      end else begin
         vram_wr_en <= 1'b0;
         pal_wr_en  <= 1'b0;
         if (reg_wr) begin
            case (cpu_addr[6:0])
               REG_DL_LO:     dl_reg[7:0]  <= cpu_wr_data;
               REG_DL_HI:     dl_reg[15:8] <= cpu_wr_data;
               REG_CHARSET:   charset_base <= cpu_wr_data;
               REG_PAL_INDEX: begin
                  pal_idx <= cpu_wr_data;
                  pal_hi  <= 1'b0;
               end
               REG_PAL_DATA: begin
                  if (pal_hi) begin
                     pal_wr_en <= 1'b1;   // pair lands next cycle
                     pal_idx   <= pal_idx + 1'b1;
                  end
                  pal_hi <= !pal_hi;
               end
               REG_VADDR_LO:  vaddr[7:0]  <= cpu_wr_data;
               REG_VADDR_HI:  vaddr[15:8] <= cpu_wr_data;
               REG_VADDR_TOP: vaddr[16]   <= cpu_wr_data[0];
               REG_VDATA: begin
                  vram_wr_en <= 1'b1;
                  vaddr      <= vaddr + 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (reg_wr && cpu_addr[6:0] == REG_PAL_DATA) begin
         if (pal_hi) begin
            pal_wr_data <= {cpu_wr_data, pal_lo};
            pal_wr_addr <= pal_idx;
         end else begin
            pal_lo <= cpu_wr_data;
         end
      end
      if (reg_wr && cpu_addr[6:0] == REG_VDATA) begin
         vram_wr_data <= cpu_wr_data;
         vram_wr_addr <= vaddr;
      end
   end

endmodule

`default_nettype wire

// ==== source/vram.sv ====
`default_nettype none

module vram (
   input  wire                         sys_clk,
   input  wire                         wr_en,
   input  wire chroni_pkg::vram_addr_t wr_addr,
   input  wire chroni_pkg::byte_t      wr_data,
   input  wire                         dl_reading,
   input  wire chroni_pkg::vram_addr_t dl_addr,
   input  wire chroni_pkg::vram_addr_t fetch_addr,
   output chroni_pkg::byte_t           rd_data
);
   import chroni_pkg::*;

   byte_t      mem [2**$bits(vram_addr_t)];
   vram_addr_t rd_addr;

   // display list reads take priority over the character fetcher
   assign rd_addr = dl_reading ? dl_addr : fetch_addr;

   always_ff @(posedge sys_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// ==== source/dl_engine.sv ====
`default_nettype none

module dl_engine (
   input  wire                         sys_clk,
   input  wire                         rst_n,
   input  wire                         frame_start,
   input  wire                         line_start,
   input  wire chroni_pkg::vram_addr_t dl_base,
   input  wire chroni_pkg::byte_t      rd_data,
   input  wire                         row_done,
   output logic                        dl_reading,
   output chroni_pkg::vram_addr_t      dl_addr,
   output logic                        row_start,
   output chroni_pkg::vram_addr_t      text_addr,
   output chroni_pkg::vram_addr_t      attr_addr,
   output chroni_pkg::font_scan_t      font_scan,
   output logic                        line_busy
);
   import chroni_pkg::*;

   dl_state_t  state;
   vram_addr_t dl_ptr;
   logic [3:0] inst;
   logic [2:0] lines_left;   // lines still owed by the current instruction
   logic [1:0] lms_part;

   assign dl_addr    = dl_ptr;
   assign dl_reading = state inside {DLS_READ, DLS_READ_WAIT, DLS_LMS, DLS_LMS_READ};

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= DLS_IDLE;
         dl_ptr     <= '0;
         inst       <= DL_END;   // nothing is shown until the first frame_start
         lines_left <= '0;
         lms_part   <= '0;
         row_start  <= 1'b0;
         line_busy  <= 1'b0;
         text_addr  <= '0;
         attr_addr  <= '0;
         font_scan  <= '0;
      end else begin
         row_start <= 1'b0;
         case (state)
            DLS_IDLE: begin
               if (line_start) begin
                  line_busy <= 1'b1;
                  if (lines_left != '0) begin
                     lines_left <= lines_left - 1'b1;
                     state      <= DLS_EXEC;
                  end else if (inst == DL_END) begin
                     state <= DLS_EXEC;
                  end else begin
                     state <= DLS_READ;
                  end
               end
            end
            DLS_READ: state <= DLS_READ_WAIT;   // vram samples dl_ptr
            DLS_READ_WAIT: begin
               inst       <= rd_data[3:0];
               dl_ptr     <= dl_ptr + 1'b1;
               lines_left <= '0;
               state      <= DLS_EXEC;
               if (rd_data[3:0] == DL_BLANK) begin
                  lines_left <= rd_data[6:4];
               end else if (rd_data[3:0] == DL_TEXT) begin
                  lines_left <= 3'(CELL_LINES - 1);
                  font_scan  <= '0;
                  if (rd_data[DL_LMS_BIT]) begin
                     state <= DLS_LMS;
                  end
               end
            end
            DLS_LMS: state <= DLS_LMS_READ;
            DLS_LMS_READ: begin
               // text lo, text hi, attr lo, attr hi
               case (lms_part)
                  2'd0: text_addr[7:0]  <= rd_data;
                  2'd1: text_addr[16:8] <= {1'b0, rd_data};
                  2'd2: attr_addr[7:0]  <= rd_data;
                  2'd3: attr_addr[16:8] <= {1'b0, rd_data};
                  default: ;
               endcase
               dl_ptr   <= dl_ptr + 1'b1;
               lms_part <= lms_part + 1'b1;
               state    <= (lms_part == 2'd3) ? DLS_EXEC : DLS_LMS;
            end
            DLS_EXEC: begin
               if (inst == DL_TEXT) begin
                  row_start <= 1'b1;
                  state     <= DLS_WAIT_LINE;
               end else begin
                  line_busy <= 1'b0;   // blank line ends at once
                  state     <= DLS_IDLE;
               end
            end
            DLS_WAIT_LINE: begin
               if (row_done) begin
                  line_busy <= 1'b0;
                  state     <= DLS_IDLE;
                  font_scan <= font_scan + 1'b1;
                  if (font_scan == font_scan_t'(CELL_LINES - 1)) begin
                     text_addr <= text_addr + vram_addr_t'(TEXT_COLS);
                     attr_addr <= attr_addr + vram_addr_t'(TEXT_COLS);
                  end
               end
            end
            default: state <= DLS_IDLE;
         endcase
         if (frame_start) begin
            dl_ptr     <= dl_base;
            inst       <= DL_BLANK;
            lines_left <= '0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/char_fetch.sv ====
`default_nettype none

module char_fetch (
   input  wire                         sys_clk,
   input  wire                         rst_n,
   input  wire                         row_start,
   input  wire chroni_pkg::vram_addr_t text_addr,
   input  wire chroni_pkg::vram_addr_t attr_addr,
   input  wire chroni_pkg::font_scan_t font_scan,
   input  wire chroni_pkg::byte_t      charset_base,
   input  wire chroni_pkg::byte_t      rd_data,
   output chroni_pkg::vram_addr_t      fetch_addr,
   output logic                        row_done,
   output logic                        glyph_req,
   output chroni_pkg::byte_t           glyph_bits,
   output chroni_pkg::byte_t           glyph_attr,
   input  wire                         glyph_ack
);
   import chroni_pkg::*;

   fetch_state_t state;
   col_idx_t     col;
   byte_t        text_buf [TEXT_COLS];
   byte_t        attr_buf [TEXT_COLS];
   logic         ld_valid;   // rd_data holds a row byte this cycle
   logic         ld_attr;
   col_idx_t     ld_col;
   logic         row_pend;
   logic         last_col;
   byte_t        cur_char;
   logic [6:0]   font_page;

   assign last_col  = col == col_idx_t'(TEXT_COLS - 1);
   assign cur_char  = text_buf[col[$clog2(TEXT_COLS)-1:0]];
   assign font_page = charset_base[6:0] + 7'(cur_char[7]);

   always_comb begin
      case (state)
         FS_TEXT_READ: fetch_addr = text_addr + vram_addr_t'(col);
         FS_ATTR_READ: fetch_addr = attr_addr + vram_addr_t'(col);
         default:      fetch_addr = {font_page, cur_char[6:0], font_scan};
      endcase
   end

   always_ff @(posedge sys_clk) begin
      if (ld_valid) begin
         if (ld_attr) begin
            attr_buf[ld_col[$clog2(TEXT_COLS)-1:0]] <= rd_data;
         end else begin
            text_buf[ld_col[$clog2(TEXT_COLS)-1:0]] <= rd_data;
         end
      end
      if (state == FS_FONT_WAIT) begin
         glyph_bits <= rd_data;
         glyph_attr <= attr_buf[col[$clog2(TEXT_COLS)-1:0]];
      end
   end

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= FS_IDLE;
         col       <= '0;
         ld_valid  <= 1'b0;
         ld_attr   <= 1'b0;
         ld_col    <= '0;
         row_pend  <= 1'b0;
         row_done  <= 1'b0;
         glyph_req <= 1'b0;
      end else begin
         row_done <= 1'b0;
         ld_valid <= 1'b0;
         case (state)
            FS_IDLE: begin
               // row ends once pixel_out has drained the last glyph
               if (row_pend && !glyph_ack) begin
                  row_done <= 1'b1;
                  row_pend <= 1'b0;
               end
               if (row_start) begin
                  col   <= '0;
                  state <= (font_scan == '0) ? FS_TEXT_READ : FS_FONT_ADDR;
               end
            end
            FS_TEXT_READ, FS_ATTR_READ: begin
               ld_valid <= 1'b1;
               ld_attr  <= state == FS_ATTR_READ;
               ld_col   <= col;
               if (last_col) begin
                  col   <= '0;
                  state <= (state == FS_TEXT_READ) ? FS_ATTR_READ : FS_FONT_ADDR;
               end else begin
                  col <= col + 1'b1;
               end
            end
            FS_FONT_ADDR: state <= FS_FONT_WAIT;
            FS_FONT_WAIT: state <= FS_GLYPH_SEND;
            FS_GLYPH_SEND: begin
               if (glyph_req) begin
                  if (glyph_ack) begin
                     glyph_req <= 1'b0;
                     if (last_col) begin
                        row_pend <= 1'b1;
                        state    <= FS_IDLE;
                     end else begin
                        col   <= col + 1'b1;
                        state <= FS_FONT_ADDR;   // fetch ahead while pixels shift
                     end
                  end
               end else if (!glyph_ack) begin
                  glyph_req <= 1'b1;
               end
            end
            default: state <= FS_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== source/pixel_out.sv ====
`default_nettype none

module pixel_out (
   input  wire                         sys_clk,
   input  wire                         rst_n,
   input  wire                         pal_wr_en,
   input  wire chroni_pkg::pal_idx_t   pal_wr_addr,
   input  wire chroni_pkg::color_t     pal_wr_data,
   input  wire                         glyph_req,
   input  wire chroni_pkg::byte_t      glyph_bits,
   input  wire chroni_pkg::byte_t      glyph_attr,
   output logic                        glyph_ack,
   output logic                        px_req,
   output chroni_pkg::color_t          px_color,
   input  wire                         px_ack
);
   import chroni_pkg::*;

   color_t     palette [2**$bits(pal_idx_t)];
   byte_t      shift;
   byte_t      attr;
   logic [3:0] px_left;
   logic       px_idle;
   logic       take;
   logic       emit;
   pal_idx_t   px_idx;

   assign px_idle = (px_left == '0) && !px_req && !px_ack;   // shifter empty, bus quiet
   assign take    = glyph_req && !glyph_ack && px_idle;
   assign emit    = (px_left != '0) && !px_req && !px_ack;
   assign px_idx  = {4'h0, shift[7] ? attr[3:0] : attr[7:4]};   // fg low nibble, bg high

   always_ff @(posedge sys_clk) begin
      if (pal_wr_en) begin
         palette[pal_wr_addr] <= pal_wr_data;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (take) begin
         shift <= glyph_bits;
         attr  <= glyph_attr;
      end else if (emit) begin
         shift    <= {shift[6:0], 1'b0};
         px_color <= palette[px_idx];
      end
   end

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         glyph_ack <= 1'b0;
         px_req    <= 1'b0;
         px_left   <= '0;
      end else begin
         // ack stays up until the glyph's last pixel is done
         if (take) begin
            glyph_ack <= 1'b1;
            px_left   <= 4'($bits(byte_t));
         end else if (glyph_ack && !glyph_req && px_idle) begin
            glyph_ack <= 1'b0;
         end
         if (emit) begin
            px_req  <= 1'b1;
            px_left <= px_left - 1'b1;
         end else if (px_req && px_ack) begin
            px_req <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/chroni_top.sv ====
`default_nettype none

module chroni_top (
   input  wire                         sys_clk,
   input  wire                         rst_n,
   input  wire [15:0]                  cpu_addr,
   input  wire chroni_pkg::byte_t      cpu_wr_data,
   input  wire                         cpu_wr_en,
   input  wire                         frame_start,
   input  wire                         line_start,
   output logic                        line_busy,
   output logic                        px_req,
   output chroni_pkg::color_t          px_color,
   input  wire                         px_ack
);
   import chroni_pkg::*;

   vram_addr_t dl_base;
   byte_t      charset_base;
   logic       vram_wr_en;
   vram_addr_t vram_wr_addr;
   byte_t      vram_wr_data;
   logic       pal_wr_en;
   pal_idx_t   pal_wr_addr;
   color_t     pal_wr_data;
   byte_t      rd_data;
   logic       dl_reading;
   vram_addr_t dl_addr;
   vram_addr_t fetch_addr;
   logic       row_start;
   logic       row_done;
   vram_addr_t text_addr;
   vram_addr_t attr_addr;
   font_scan_t font_scan;
   logic       glyph_req;
   logic       glyph_ack;
   byte_t      glyph_bits;
   byte_t      glyph_attr;

   reg_decode u_reg_decode (.*);

   vram u_vram (
      .sys_clk    (sys_clk),
      .wr_en      (vram_wr_en),
      .wr_addr    (vram_wr_addr),
      .wr_data    (vram_wr_data),
      .dl_reading (dl_reading),
      .dl_addr    (dl_addr),
      .fetch_addr (fetch_addr),
      .rd_data    (rd_data)
   );

   dl_engine u_dl_engine (.*);

   char_fetch u_char_fetch (.*);

   pixel_out u_pixel_out (.*);

endmodule

`default_nettype wire

// ==== test/chroni_sva.sv ====
`default_nettype none

module chroni_sva (
   input wire sys_clk,
   input wire rst_n,
   input wire line_busy,
   input wire px_req,
   input wire px_ack,
   input wire glyph_req,
   input wire glyph_ack
);

   // requests hold until acknowledged
   px_req_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
      px_req && !px_ack |=> px_req)
      else $error("px_req fell before px_ack");

   glyph_req_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
      glyph_req && !glyph_ack |=> glyph_req)
      else $error("glyph_req fell before glyph_ack");

   px_ack_rise: assert property (@(posedge sys_clk) disable iff (!rst_n)
      $rose(px_ack) |-> px_req)
      else $error("px_ack rose without px_req");

   glyph_ack_rise: assert property (@(posedge sys_clk) disable iff (!rst_n)
      $rose(glyph_ack) |-> glyph_req)
      else $error("glyph_ack rose without glyph_req");

   // outputs come out of reset quiet
   reset_quiet: assert property (@(posedge sys_clk)
      !rst_n |=> !line_busy && !px_req && !glyph_req)
      else $error("handshake outputs not low after reset");

endmodule

bind chroni_top chroni_sva u_sva (
   .sys_clk   (sys_clk),
   .rst_n     (rst_n),
   .line_busy (line_busy),
   .px_req    (px_req),
   .px_ack    (px_ack),
   .glyph_req (glyph_req),
   .glyph_ack (glyph_ack)
);

`default_nettype wire

// ==== test/chroni_model.svh ====
`ifndef CHRONI_MODEL_SVH
`define CHRONI_MODEL_SVH

// reference copies of what the testbench has written
byte_t      m_vram [2**17];
color_t     m_pal [256];
byte_t      m_charset;
vram_addr_t m_dl_base;

// display list position and the current row
vram_addr_t m_dl_ptr;
logic [3:0] m_inst;
int         m_lines_left;   // lines still owed by the current instruction
vram_addr_t m_text;
vram_addr_t m_attr;
int         m_scan;

function automatic void reset_reference();
   m_charset    = '0;
   m_dl_base    = '0;
   m_dl_ptr     = '0;
   m_inst       = DL_END;   // nothing shows before the first frame
   m_lines_left = 0;
   m_text       = '0;
   m_attr       = '0;
   m_scan       = 0;
endfunction

function automatic void restart_list();
   m_dl_ptr     = m_dl_base;
   m_inst       = DL_BLANK;
   m_lines_left = 0;
endfunction

// pushes the colours of the next scanline onto exp_q
function automatic void predict_line();
   byte_t      op;
   byte_t      ch;
   byte_t      atr;
   byte_t      bits;
   vram_addr_t fa;

   if (m_lines_left > 0) begin
      m_lines_left = m_lines_left - 1;
   end else if (m_inst != DL_END) begin
      op           = m_vram[m_dl_ptr];
      m_dl_ptr     = m_dl_ptr + 17'd1;
      m_inst       = op[3:0];
      m_lines_left = 0;
      if (m_inst == DL_BLANK) begin
         m_lines_left = int'(op[6:4]);
      end else if (m_inst == DL_TEXT) begin
         m_lines_left = CELL_LINES - 1;
         m_scan       = 0;
         if (op[DL_LMS_BIT]) begin
            m_text   = {1'b0, m_vram[m_dl_ptr + 17'd1], m_vram[m_dl_ptr]};
            m_attr   = {1'b0, m_vram[m_dl_ptr + 17'd3], m_vram[m_dl_ptr + 17'd2]};
            m_dl_ptr = m_dl_ptr + 17'd4;
         end
      end
   end
   if (m_inst == DL_TEXT) begin
      for (int c = 0; c < TEXT_COLS; c++) begin
         ch   = m_vram[m_text + 17'(c)];
         atr  = m_vram[m_attr + 17'(c)];
         fa   = {m_charset[6:0], 10'h000} + {6'h00, ch, 3'b000} + 17'(m_scan);
         bits = m_vram[fa];
         for (int b = 7; b >= 0; b--) begin
            exp_q.push_back(bits[b] ? m_pal[atr[3:0]] : m_pal[atr[7:4]]);   // msb first
         end
      end
      m_scan = m_scan + 1;
      if (m_scan == CELL_LINES) begin
         m_scan = 0;
         m_text = m_text + 17'(TEXT_COLS);
         m_attr = m_attr + 17'(TEXT_COLS);
      end
   end
endfunction

`endif

// ==== test/chroni_tb.sv ====
`default_nettype none

module chroni_tb;
   import chroni_pkg::*;

   localparam int MAX_ACK_DELAY = 3;
   localparam int TEST_LINES    = 80;     // upper bound over all tests
   localparam int CPU_WRITES    = 5000;
   localparam longint WATCHDOG_TIME =
      longint'(TEST_LINES * TEXT_COLS * 8 * (MAX_ACK_DELAY + 6) + CPU_WRITES * 2) * 8 * 2;

   logic        sys_clk = 1'b0;
   logic        rst_n;
   logic [15:0] cpu_addr;
   byte_t       cpu_wr_data;
   logic        cpu_wr_en;
   logic        frame_start;
   logic        line_start;
   logic        line_busy;
   logic        px_req;
   color_t      px_color;
   logic        px_ack;

   integer      seed;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          max_delay;
   int          rx_count;
   color_t      exp_q [$];   // colours still expected on this line
   color_t      rx_log [$];
   byte_t       stage [$];

   `include "chroni_model.svh"

   chroni_top DUT (
      .sys_clk     (sys_clk),
      .rst_n       (rst_n),
      .cpu_addr    (cpu_addr),
      .cpu_wr_data (cpu_wr_data),
      .cpu_wr_en   (cpu_wr_en),
      .frame_start (frame_start),
      .line_start  (line_start),
      .line_busy   (line_busy),
      .px_req      (px_req),
      .px_color    (px_color),
      .px_ack      (px_ack)
   );

   always #4 sys_clk = ~sys_clk;

   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   function automatic byte_t rand_byte();
      return byte_t'($random(seed));
   endfunction

   function automatic byte_t encode_instr(input logic [3:0] op, input logic [2:0] hi);
      byte_t r;
      r = rand_byte();   // bit 7 is don't care
      return {r[7], hi, op};
   endfunction

   task automatic cpu_write(input logic [6:0] reg_off, input byte_t data);
      @(posedge sys_clk);
      cpu_addr    <= {REG_BASE, reg_off};
      cpu_wr_data <= data;
      cpu_wr_en   <= 1'b1;
      @(posedge sys_clk);
      cpu_wr_en   <= 1'b0;
   endtask

   // writes the staged bytes through the auto-incrementing vram port
   task automatic load_stage(input vram_addr_t start);
      cpu_write(REG_VADDR_LO, start[7:0]);
      cpu_write(REG_VADDR_HI, start[15:8]);
      cpu_write(REG_VADDR_TOP, {7'h00, start[16]});
      foreach (stage[i]) begin
         cpu_write(REG_VDATA, stage[i]);
         m_vram[start + 17'(i)] = stage[i];
      end
      stage.delete();
   endtask

   task automatic load_palette();
      color_t c;
      cpu_write(REG_PAL_INDEX, 8'h00);   // one index write for all sixteen
      for (int i = 0; i < 16; i++) begin
         c = color_t'($random(seed));
         cpu_write(REG_PAL_DATA, c[7:0]);
         cpu_write(REG_PAL_DATA, c[15:8]);
         m_pal[i] = c;
      end
   endtask

   task automatic load_font(input byte_t cs);
      cpu_write(REG_CHARSET, cs);
      m_charset = cs;
      repeat (256 * 8) stage.push_back(rand_byte());
      load_stage({cs[6:0], 10'h000});
   endtask

   task automatic load_rows(input vram_addr_t text_a, input vram_addr_t attr_a, input int n);
      repeat (n) stage.push_back(rand_byte());
      load_stage(text_a);
      repeat (n) stage.push_back(rand_byte());
      load_stage(attr_a);
   endtask

   task automatic stage_lms(input vram_addr_t text_a, input vram_addr_t attr_a);
      stage.push_back(encode_instr(DL_TEXT, {1'b1, 2'(rand_byte())}));
      stage.push_back(text_a[7:0]);
      stage.push_back(text_a[15:8]);
      stage.push_back(attr_a[7:0]);
      stage.push_back(attr_a[15:8]);
   endtask

   task automatic load_list(input vram_addr_t base);
      load_stage(base);
      cpu_write(REG_DL_LO, base[7:0]);
      cpu_write(REG_DL_HI, base[15:8]);
      m_dl_base = base;
   endtask

   task automatic start_frame();
      restart_list();
      @(posedge sys_clk);
      frame_start <= 1'b1;
      @(posedge sys_clk);
      frame_start <= 1'b0;
   endtask

   task automatic run_line();
      int n_exp;
      exp_q.delete();
      predict_line();
      n_exp    = exp_q.size();
      rx_count = 0;
      @(posedge sys_clk);
      line_start <= 1'b1;
      @(posedge sys_clk);
      line_start <= 1'b0;
      @(negedge sys_clk);
      check_equal(line_busy, 1'b1, "line_busy after line_start");
      while (line_busy) @(negedge sys_clk);
      check_equal(rx_count, n_exp, "pixels on line");
   endtask

   task automatic report_test(input string name, input int err_start);
      tests_run++;
      if (errors == err_start) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - err_start);
      end
   endtask

   // pixel sink acks each pixel after a random delay
   always begin : pixel_sink
      int wait_cycles;
      @(negedge sys_clk);
      if (rst_n && px_req && !px_ack) begin
         rx_log.push_back(px_color);
         rx_count++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("unexpected pixel %h at time %0t", px_color, $time);
         end else begin
            check_equal(px_color, exp_q.pop_front(), "pixel colour");
         end
         wait_cycles = (max_delay == 0) ? 0 : int'($unsigned($random(seed)) % (max_delay + 1));
         repeat (wait_cycles) @(posedge sys_clk);
         @(posedge sys_clk);
         px_ack <= 1'b1;
         @(negedge sys_clk);
         while (px_req) @(negedge sys_clk);
         @(posedge sys_clk);
         px_ack <= 1'b0;
      end
   end

   initial begin : watchdog
      #(WATCHDOG_TIME);
      $display("timeout: run did not finish within %0d time units", WATCHDOG_TIME);
      $display(">>> FAIL");
      $finish;
   end

   initial begin : main
      vram_addr_t text_a;
      vram_addr_t attr_a;
      color_t     first_run [$];
      int         err_start;
      int         n_blank;

      rst_n       = 1'b0;
      cpu_addr    = '0;
      cpu_wr_data = '0;
      cpu_wr_en   = 1'b0;
      frame_start = 1'b0;
      line_start  = 1'b0;
      px_ack      = 1'b0;
      seed        = 32'h5c8c_92b5;
      max_delay   = MAX_ACK_DELAY;
      reset_reference();
      repeat (10) @(posedge sys_clk);
      rst_n <= 1'b1;

      err_start = errors;
      @(negedge sys_clk);
      check_equal(px_req, 1'b0, "px_req after reset");
      check_equal(line_busy, 1'b0, "line_busy after reset");
      run_line();
      report_test("reset", err_start);

      err_start = errors;
      load_palette();
      load_font(8'h08 + (rand_byte() & 8'h07));
      text_a = 17'h01000;
      attr_a = 17'h01100;
      load_rows(text_a, attr_a, TEXT_COLS);
      stage_lms(text_a, attr_a);
      stage.push_back(encode_instr(DL_END, 3'(rand_byte())));
      load_list(17'h00100);
      start_frame();
      run_line();
      report_test("palette", err_start);

      err_start = errors;
      load_font(8'h10 + (rand_byte() & 8'h07));
      text_a = 17'h01200 + {9'h000, rand_byte() & 8'he0};
      attr_a = text_a + 17'h00400;
      load_rows(text_a, attr_a, TEXT_COLS);
      stage_lms(text_a, attr_a);
      stage.push_back(encode_instr(DL_END, 3'(rand_byte())));
      load_list(17'h00140);
      start_frame();
      repeat (CELL_LINES) run_line();
      report_test("text_row", err_start);

      err_start = errors;
      n_blank = int'(rand_byte() & 8'h07);
      stage_lms(text_a, attr_a);
      stage.push_back(encode_instr(DL_BLANK, 3'(n_blank)));
      stage_lms(text_a, attr_a);   // lands only after the right number of blanks
      stage.push_back(encode_instr(DL_END, 3'(rand_byte())));
      stage.push_back(encode_instr(DL_TEXT, {1'b0, 2'(rand_byte())}));   // never reached
      load_list(17'h00180);
      start_frame();
      repeat (2 * CELL_LINES + n_blank + 1 + 3) run_line();   // text, blanks, text, past the end
      start_frame();
      run_line();
      report_test("blank_end", err_start);

      err_start = errors;
      text_a = 17'h01800;
      attr_a = 17'h01c00;
      load_rows(text_a, attr_a, 2 * TEXT_COLS);
      stage_lms(text_a, attr_a);
      stage.push_back(encode_instr(DL_TEXT, {1'b0, 2'(rand_byte())}));
      stage.push_back(encode_instr(DL_END, 3'(rand_byte())));
      load_list(17'h001c0);
      start_frame();
      repeat (2 * CELL_LINES) run_line();
      report_test("lms_advance", err_start);

      err_start = errors;
      rx_log.delete();
      start_frame();
      repeat (CELL_LINES) run_line();
      first_run = rx_log;
      rx_log.delete();
      max_delay = 0;
      start_frame();
      repeat (CELL_LINES) run_line();
      check_equal(rx_log.size(), first_run.size(), "pixel count with immediate ack");
      foreach (first_run[i]) begin
         if (i < rx_log.size()) begin
            check_equal(rx_log[i], first_run[i], "pixel under back-pressure");
         end
      end
      report_test("backpressure", err_start);

      $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
source/chroni_pkg.sv
source/reg_decode.sv
source/vram.sv
source/dl_engine.sv
source/char_fetch.sv
source/pixel_out.sv
source/chroni_top.sv
+incdir+test
test/chroni_sva.sv
test/chroni_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module chroni_tb -f flist.f -o chroni_sim \
   && ./obj_dir/chroni_sim 2>&1 | tee sim.log \
   && grep -qx '>>> PASS' sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }
